// File: common/csr_pkg.sv
/*
 * Shared CSR unit definitions: data, counter, address and PC widths,
 * machine CSR addresses, mstatus bit positions and interrupt bit positions
 */
`default_nettype none

package csr_pkg;

   // --------------------
   // Widths with a meaning
   // --------------------
   typedef logic [31:0] xlen_t;        // One CSR data word
   typedef logic [63:0] dword_t;       // Full counter and mtime width
   typedef logic [11:0] csr_addr_t;    // CSR address space
   typedef logic [29:0] pc_word_t;     // Word aligned PC, two zero bits dropped

   // --------------------
   // Machine CSR addresses
   // --------------------
   localparam csr_addr_t CSR_MSTATUS   = 12'h300;   // Machine status
   localparam csr_addr_t CSR_MIE       = 12'h304;   // Interrupt enables
   localparam csr_addr_t CSR_MTVEC     = 12'h305;   // Trap vector base, direct mode only
   localparam csr_addr_t CSR_MSCRATCH  = 12'h340;   // Scratch word for the trap handler
   localparam csr_addr_t CSR_MEPC      = 12'h341;   // PC of the trapped instruction
   localparam csr_addr_t CSR_MCAUSE    = 12'h342;   // Trap cause
   localparam csr_addr_t CSR_MIP       = 12'h344;   // Pending interrupts, read only here
   localparam csr_addr_t CSR_MCYCLE    = 12'hB00;   // Cycle counter, low half
   localparam csr_addr_t CSR_MINSTRET  = 12'hB02;   // Retired count, low half
   localparam csr_addr_t CSR_MCYCLEH   = 12'hB80;   // Cycle counter, high half
   localparam csr_addr_t CSR_MINSTRETH = 12'hB82;   // Retired count, high half
   localparam csr_addr_t CSR_TIME      = 12'hC01;   // Platform timer, low half
   localparam csr_addr_t CSR_TIMEH     = 12'hC81;   // Platform timer, high half
   localparam csr_addr_t CSR_MHARTID   = 12'hF14;   // Hart number

   // --------------------
   // mstatus fields
   // --------------------
   localparam int MSTATUS_MIE_BIT  = 3;   // Global machine interrupt enable
   localparam int MSTATUS_MPIE_BIT = 7;   // Enable state saved on trap entry
   localparam int MSTATUS_MPP_LO   = 11;  // MPP field, hard wired to machine mode
   localparam int MSTATUS_MPP_HI   = 12;

   // --------------------
   // Interrupt positions
   // --------------------
   // Same bit in mie and mip, and the value doubles as the cause code
   localparam int IRQ_MSI_BIT = 3;        // Machine software interrupt
   localparam int IRQ_MTI_BIT = 7;        // Machine timer interrupt
   localparam int IRQ_MEI_BIT = 11;       // Machine external interrupt

endpackage

`default_nettype wire

// File: csr_file/csr_next_value.sv
/*
 * Next-state logic for the machine CSRs: trap entry, mret,
 * masked CSR writes and the cycle and retired counters
 */
`timescale 1ns/1ps
`default_nettype none

module csr_next_value (
   input  logic               wr,               // Write strobe for addr
   input  logic               retired,          // Adds one to minstret
   input  logic               exception_flag,   // Trap entry, beats wr and mret
   input  logic               mret,             // Return from trap
   input  csr_pkg::csr_addr_t addr,
   input  csr_pkg::xlen_t     wr_data,
   input  csr_pkg::xlen_t     exception_cause,
   input  csr_pkg::pc_word_t  exception_pc,
   // Current state
   input  logic               mstatus_mie,
   input  logic               mstatus_mpie,
   input  csr_pkg::xlen_t     mie_bits,
   input  csr_pkg::xlen_t     mtvec,
   input  csr_pkg::xlen_t     mscratch,
   input  csr_pkg::xlen_t     mepc,
   input  csr_pkg::xlen_t     mcause,
   input  csr_pkg::dword_t    mcycle,
   input  csr_pkg::dword_t    minstret,
   // State after the next clock edge
   output logic               nxt_mstatus_mie,
   output logic               nxt_mstatus_mpie,
   output csr_pkg::xlen_t     nxt_mie_bits,
   output csr_pkg::xlen_t     nxt_mtvec,
   output csr_pkg::xlen_t     nxt_mscratch,
   output csr_pkg::xlen_t     nxt_mepc,
   output csr_pkg::xlen_t     nxt_mcause,
   output csr_pkg::dword_t    nxt_mcycle,
   output csr_pkg::dword_t    nxt_minstret
);
   import csr_pkg::*;

   // Only the three machine interrupt enables are implemented
   localparam xlen_t MIE_MASK = (xlen_t'(1) << IRQ_MSI_BIT) |
                                (xlen_t'(1) << IRQ_MTI_BIT) |
                                (xlen_t'(1) << IRQ_MEI_BIT);

   logic wr_en;                                            // A write that is not overridden by a trap

   assign wr_en = wr & ~exception_flag;

   // --------------------
   // mstatus
   // --------------------
   always_comb begin
      nxt_mstatus_mie  = mstatus_mie;
      nxt_mstatus_mpie = mstatus_mpie;
      if (exception_flag) begin
         nxt_mstatus_mpie = mstatus_mie;                   // Save enable, then mask interrupts
         nxt_mstatus_mie  = 1'b0;
      end else if (mret) begin
         nxt_mstatus_mie  = mstatus_mpie;                  // Restore saved enable
         nxt_mstatus_mpie = 1'b1;
      end else if (wr_en && (addr == CSR_MSTATUS)) begin
         nxt_mstatus_mie  = wr_data[MSTATUS_MIE_BIT];      // All other mstatus bits are dropped
         nxt_mstatus_mpie = wr_data[MSTATUS_MPIE_BIT];
      end
   end

   // --------------------
   // Trap and plain registers
   // --------------------
   always_comb begin
      nxt_mie_bits = mie_bits;
      nxt_mtvec    = mtvec;
      nxt_mscratch = mscratch;
      nxt_mepc     = mepc;
      nxt_mcause   = mcause;
      if (exception_flag) begin
         nxt_mepc   = {exception_pc, 2'b00};              // PC of the faulting instruction
         nxt_mcause = exception_cause;
      end else if (wr_en) begin                           // mret leaves these free to write
         case (addr)
            CSR_MIE:      nxt_mie_bits = wr_data & MIE_MASK;
            CSR_MTVEC:    nxt_mtvec    = {wr_data[31:2], 2'b00};   // Direct mode, word aligned
            CSR_MSCRATCH: nxt_mscratch = wr_data;
            CSR_MEPC:     nxt_mepc     = {wr_data[31:2], 2'b00};
            CSR_MCAUSE:   nxt_mcause   = wr_data;
            default:      ;                               // mip, time, mhartid ignore writes
         endcase
      end
   end

   // --------------------
   // Counters
   // --------------------
   // A write to either half replaces it and that cycle's increment is lost
   always_comb begin
      nxt_mcycle   = mcycle + dword_t'(1);
      nxt_minstret = minstret + dword_t'(retired);
      if (wr_en) begin
         case (addr)
            CSR_MCYCLE:    nxt_mcycle   = {mcycle[63:32], wr_data};
            CSR_MCYCLEH:   nxt_mcycle   = {wr_data, mcycle[31:0]};
            CSR_MINSTRET:  nxt_minstret = {minstret[63:32], wr_data};
            CSR_MINSTRETH: nxt_minstret = {wr_data, minstret[31:0]};
            default:       ;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: csr_file/csr_registers.sv
/*
 * Clocked storage of the machine CSR state, loaded from the next-state logic
 */
`timescale 1ns/1ps
`default_nettype none

module csr_registers #(
   parameter csr_pkg::xlen_t MTVEC_RESET = 32'h0000_0000   // Trap base right after reset
) (
   input  logic            clk_in,
   input  logic            reset,              // Synchronous, active high
   input  logic            nxt_mstatus_mie,
   input  logic            nxt_mstatus_mpie,
   input  csr_pkg::xlen_t  nxt_mie_bits,
   input  csr_pkg::xlen_t  nxt_mtvec,
   input  csr_pkg::xlen_t  nxt_mscratch,
   input  csr_pkg::xlen_t  nxt_mepc,
   input  csr_pkg::xlen_t  nxt_mcause,
   input  csr_pkg::dword_t nxt_mcycle,
   input  csr_pkg::dword_t nxt_minstret,
   output logic            mstatus_mie,
   output logic            mstatus_mpie,
   output csr_pkg::xlen_t  mie_bits,
   output csr_pkg::xlen_t  mtvec,
   output csr_pkg::xlen_t  mscratch,
   output csr_pkg::xlen_t  mepc,
   output csr_pkg::xlen_t  mcause,
   output csr_pkg::dword_t mcycle,
   output csr_pkg::dword_t minstret
);

   // Status, enables and trap registers
   always_ff @(posedge clk_in) begin
      if (reset) begin
         mstatus_mie  <= 1'b0;                         // Interrupts masked out of reset
         mstatus_mpie <= 1'b0;
         mie_bits     <= '0;
         mtvec        <= MTVEC_RESET;
         mscratch     <= '0;
         mepc         <= '0;
         mcause       <= '0;
      end else begin
         mstatus_mie  <= nxt_mstatus_mie;
         mstatus_mpie <= nxt_mstatus_mpie;
         mie_bits     <= nxt_mie_bits;
         mtvec        <= nxt_mtvec;
         mscratch     <= nxt_mscratch;
         mepc         <= nxt_mepc;
         mcause       <= nxt_mcause;
      end
   end

   // Counters read 0 in the first cycle after reset is released
   always_ff @(posedge clk_in) begin
      if (reset) begin
         mcycle   <= '0;
         minstret <= '0;
      end else begin
         mcycle   <= nxt_mcycle;
         minstret <= nxt_minstret;
      end
   end

endmodule

`default_nettype wire

// File: csr_file/csr_read_mux.sv
/*
 * CSR read decode: returns the addressed CSR and whether it exists
 */
`timescale 1ns/1ps
`default_nettype none

module csr_read_mux #(
   parameter csr_pkg::xlen_t HART_ID = 32'h0000_0000       // Fixed mhartid value
) (
   input  csr_pkg::csr_addr_t addr,
   input  logic               mstatus_mie,
   input  logic               mstatus_mpie,
   input  csr_pkg::xlen_t     mie_bits,
   input  csr_pkg::xlen_t     mtvec,
   input  csr_pkg::xlen_t     mscratch,
   input  csr_pkg::xlen_t     mepc,
   input  csr_pkg::xlen_t     mcause,
   input  csr_pkg::dword_t    mcycle,
   input  csr_pkg::dword_t    minstret,
   input  csr_pkg::dword_t    mtime,
   input  logic               ext_irq,
   input  logic               timer_irq,
   input  logic               sw_irq,
   output csr_pkg::xlen_t     data,
   output logic               avail              // Low for an address that is not implemented
);
   import csr_pkg::*;

   xlen_t mstatus_word;                          // mstatus as software sees it
   xlen_t mip_word;                              // Live pending bits

   always_comb begin
      mstatus_word = '0;
      mstatus_word[MSTATUS_MIE_BIT]  = mstatus_mie;
      mstatus_word[MSTATUS_MPIE_BIT] = mstatus_mpie;
      mstatus_word[MSTATUS_MPP_HI:MSTATUS_MPP_LO] = 2'b11;  // Machine mode only
      mip_word = '0;
      mip_word[IRQ_MEI_BIT] = ext_irq;
      mip_word[IRQ_MTI_BIT] = timer_irq;
      mip_word[IRQ_MSI_BIT] = sw_irq;
   end

   always_comb begin
      avail = 1'b1;
      case (addr)
         CSR_MSTATUS:   data = mstatus_word;
         CSR_MIE:       data = mie_bits;
         CSR_MTVEC:     data = mtvec;
         CSR_MSCRATCH:  data = mscratch;
         CSR_MEPC:      data = mepc;
         CSR_MCAUSE:    data = mcause;
         CSR_MIP:       data = mip_word;
         CSR_MCYCLE:    data = mcycle[31:0];
         CSR_MCYCLEH:   data = mcycle[63:32];
         CSR_MINSTRET:  data = minstret[31:0];
         CSR_MINSTRETH: data = minstret[63:32];
         CSR_TIME:      data = mtime[31:0];
         CSR_TIMEH:     data = mtime[63:32];
         CSR_MHARTID:   data = HART_ID;
         default: begin
            data  = '0;                          // Unknown CSR reads as zero
            avail = 1'b0;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: hdl/trap_control.sv
/*
 * Interrupt request detection, cause priority and trap vector address
 */
`timescale 1ns/1ps
`default_nettype none

module trap_control (
   input  logic              mstatus_mie,        // Global enable
   input  csr_pkg::xlen_t    mie_bits,           // Per source enables
   input  csr_pkg::xlen_t    mtvec,
   input  logic              ext_irq,
   input  logic              timer_irq,
   input  logic              sw_irq,
   output logic              irq_flag,           // Take an interrupt trap
   output csr_pkg::xlen_t    irq_cause,          // Interrupt bit set plus winning source
   output csr_pkg::pc_word_t trap_pc             // Handler address, word aligned
);
   import csr_pkg::*;

   xlen_t mip_bits;                              // Levels placed at their mip positions
   xlen_t pending;                               // Enabled and asserted sources

   always_comb begin
      mip_bits = '0;
      mip_bits[IRQ_MEI_BIT] = ext_irq;
      mip_bits[IRQ_MTI_BIT] = timer_irq;
      mip_bits[IRQ_MSI_BIT] = sw_irq;
   end

   assign pending  = mie_bits & mip_bits;
   assign irq_flag = mstatus_mie & (|pending);

   // External first, then software, then timer
   always_comb begin
      irq_cause = '0;
      if (pending[IRQ_MEI_BIT])
         irq_cause = {1'b1, 31'(IRQ_MEI_BIT)};
      else if (pending[IRQ_MSI_BIT])
         irq_cause = {1'b1, 31'(IRQ_MSI_BIT)};
      else if (pending[IRQ_MTI_BIT])
         irq_cause = {1'b1, 31'(IRQ_MTI_BIT)};
   end

   assign trap_pc = mtvec[31:2];                 // Direct mode, every trap goes to the base

endmodule

`default_nettype wire

// File: hdl/csr_unit.sv
/*
 * Machine mode CSR unit top level. Connects the write-back update path,
 * the execute stage forward path, CSR storage, both read ports and trap control
 */
`timescale 1ns/1ps
`default_nettype none

module csr_unit #(
   parameter csr_pkg::xlen_t MTVEC_RESET = 32'h0000_0100,   // mtvec after reset
   parameter csr_pkg::xlen_t HART_ID     = 32'h0000_0000    // Value read from mhartid
) (
   input  logic               clk_in,
   input  logic               reset,
   // Write-back stage
   input  logic               wr,               // One cycle write strobe
   input  csr_pkg::csr_addr_t wr_addr,
   input  csr_pkg::xlen_t     wr_data,
   input  logic               retired,          // One instruction retires this cycle
   input  logic               exception_flag,   // Retiring instruction traps
   input  csr_pkg::xlen_t     exception_cause,
   input  csr_pkg::pc_word_t  exception_pc,
   input  logic               mret,
   // Execute stage read and forward ports
   input  csr_pkg::csr_addr_t rd_addr,
   output csr_pkg::xlen_t     rd_data,
   output logic               rd_avail,         // High when rd_addr names an existing CSR
   input  logic               nxt_wr,
   input  csr_pkg::csr_addr_t nxt_wr_addr,
   input  csr_pkg::xlen_t     nxt_wr_data,
   output csr_pkg::xlen_t     nxt_rd_data,      // Value nxt_wr_addr holds after the next edge
   // Interrupt sources and platform timer
   input  logic               ext_irq,
   input  logic               timer_irq,
   input  logic               sw_irq,
   input  csr_pkg::dword_t    mtime,
   // Trap request to the execute stage
   output csr_pkg::pc_word_t  trap_pc,
   output logic               irq_flag,
   output csr_pkg::xlen_t     irq_cause
);
   import csr_pkg::*;

   logic   mstatus_mie,     mstatus_mpie;        // Current machine state
   xlen_t  mie_bits,        mtvec,    mscratch,   mepc,   mcause;
   dword_t mcycle,          minstret;
   logic   nxt_mstatus_mie, nxt_mstatus_mpie;    // State after the next edge
   xlen_t  nxt_mie_bits,    nxt_mtvec, nxt_mscratch, nxt_mepc, nxt_mcause;
   dword_t nxt_mcycle,      nxt_minstret;
   logic   fwd_mstatus_mie, fwd_mstatus_mpie;    // Predicted state for forwarding
   xlen_t  fwd_mie_bits,    fwd_mtvec, fwd_mscratch, fwd_mepc, fwd_mcause;
   dword_t fwd_mcycle,      fwd_minstret;

   // --------------------
   // Real update path
   // --------------------
   csr_next_value main (.addr(wr_addr), .*);                 // Write-back drives the real write

   csr_registers #(.MTVEC_RESET(MTVEC_RESET)) regs (.*);     // Storage, names match one to one

   csr_read_mux #(.HART_ID(HART_ID)) rd_mux (
      .addr(rd_addr), .data(rd_data), .avail(rd_avail), .*
   );

   trap_control trap (.*);                                    // Interrupt request and vector

   // --------------------
   // Forward path
   // --------------------
   // Same events as the real path but the write comes from execute, nothing is stored
   csr_next_value forward (
      .wr(nxt_wr), .addr(nxt_wr_addr), .wr_data(nxt_wr_data),
      .retired(retired), .exception_flag(exception_flag), .mret(mret),
      .exception_cause(exception_cause), .exception_pc(exception_pc),
      .mstatus_mie(mstatus_mie), .mstatus_mpie(mstatus_mpie), .mie_bits(mie_bits),
      .mtvec(mtvec), .mscratch(mscratch), .mepc(mepc), .mcause(mcause),
      .mcycle(mcycle), .minstret(minstret),
      .nxt_mstatus_mie(fwd_mstatus_mie), .nxt_mstatus_mpie(fwd_mstatus_mpie),
      .nxt_mie_bits(fwd_mie_bits), .nxt_mtvec(fwd_mtvec), .nxt_mscratch(fwd_mscratch),
      .nxt_mepc(fwd_mepc), .nxt_mcause(fwd_mcause),
      .nxt_mcycle(fwd_mcycle), .nxt_minstret(fwd_minstret)
   );

   csr_read_mux #(.HART_ID(HART_ID)) fwd_mux (
      .addr(nxt_wr_addr), .data(nxt_rd_data), .avail(),      // Exists flag not needed here
      .mstatus_mie(fwd_mstatus_mie), .mstatus_mpie(fwd_mstatus_mpie),
      .mie_bits(fwd_mie_bits), .mtvec(fwd_mtvec), .mscratch(fwd_mscratch),
      .mepc(fwd_mepc), .mcause(fwd_mcause), .mcycle(fwd_mcycle), .minstret(fwd_minstret),
      .mtime(mtime), .ext_irq(ext_irq), .timer_irq(timer_irq), .sw_irq(sw_irq)
   );

endmodule

`default_nettype wire

// File: tb/csr_unit_assertions.sv
/*
 * Concurrent checks on the CSR unit: unknown reads, interrupt request, trap entry
 */
`timescale 1ns/1ps
`default_nettype none

module csr_unit_assertions (
   input logic               clk_in,
   input logic               reset,
   input csr_pkg::csr_addr_t rd_addr,
   input csr_pkg::xlen_t     rd_data,
   input logic               rd_avail,
   input logic               irq_flag,
   input logic               exception_flag,
   input csr_pkg::xlen_t     mie_bits,          // Internal enable register of the DUT
   input logic               ext_irq,
   input logic               timer_irq,
   input logic               sw_irq
);
   import csr_pkg::*;

   xlen_t mip_live;                              // Pending levels at their mip positions
   int    failures = 0;                          // Failed assertions, read by the testbench

   assign mip_live = (xlen_t'(ext_irq) << IRQ_MEI_BIT) | (xlen_t'(timer_irq) << IRQ_MTI_BIT) |
                     (xlen_t'(sw_irq) << IRQ_MSI_BIT);

   unknown_reads_zero: assert property (@(posedge clk_in) disable iff (reset)
      !rd_avail |-> rd_data == '0)
      else begin
         $error("rd_data not zero for an unknown CSR");
         failures++;
      end

   irq_needs_enabled_source: assert property (@(posedge clk_in) disable iff (reset)
      irq_flag |-> (mie_bits & mip_live) != '0)
      else begin
         $error("irq_flag without a pending source");
         failures++;
      end

   trap_masks_interrupts: assert property (@(posedge clk_in) disable iff (reset)
      exception_flag |=> (rd_addr != CSR_MSTATUS || !rd_data[MSTATUS_MIE_BIT]))
      else begin
         $error("mstatus mie still set after trap entry");
         failures++;
      end

endmodule

bind csr_unit csr_unit_assertions checks (.*);

`default_nettype wire

// File: tb/csr_unit_tb.sv
/*
 * Testbench for the CSR unit: stimulus tasks, a shadow model with its
 * reference read function, a comparing process, watchdog and summary
 */
`timescale 1ns/1ps
`default_nettype none

module csr_unit_tb;
   import csr_pkg::*;

   localparam xlen_t MTVEC_INIT = 32'h0000_0100;   // mtvec out of reset
   localparam int    NUM_TESTS  = 6;
   localparam int    PERIOD     = 100;             // Clock period in ns

   logic      clk_in = 1'b0;
   logic      reset, wr, retired, exception_flag, mret, nxt_wr;
   logic      ext_irq, timer_irq, sw_irq, rd_avail, irq_flag;
   csr_addr_t wr_addr, rd_addr, nxt_wr_addr;
   xlen_t     wr_data, nxt_wr_data, exception_cause, rd_data, nxt_rd_data, irq_cause;
   pc_word_t  exception_pc, trap_pc;
   dword_t    mtime;

   logic      m_mie, m_mpie;                      // Shadow copy of the machine state
   xlen_t     m_mie_bits, m_mtvec, m_mscratch, m_mepc, m_mcause;
   dword_t    m_mcycle, m_minstret, old_cycle, old_instret;
   logic      fwd_en, fwd_pending;                // Forward value waits one cycle for its check
   csr_addr_t fwd_addr;
   xlen_t     fwd_val;
   int        errors = 0, tests = 0, test_errors = 0;
   csr_addr_t addr_list [16] = '{CSR_MSTATUS, CSR_MIE, CSR_MTVEC, CSR_MSCRATCH,
                                 CSR_MEPC, CSR_MCAUSE, CSR_MIP, CSR_MCYCLE,
                                 CSR_MCYCLEH, CSR_MINSTRET, CSR_MINSTRETH, CSR_TIME,
                                 CSR_TIMEH, CSR_MHARTID, 12'h7C0, 12'h301};
   csr_addr_t cnt_addr [4]   = '{CSR_MINSTRET, CSR_MINSTRETH, CSR_TIME, CSR_TIMEH};

   csr_unit #(.MTVEC_RESET(MTVEC_INIT), .HART_ID(32'h0)) UUT (.*);

   always #(PERIOD / 2) clk_in = ~clk_in;

   // --------------------
   // Shadow model
   // --------------------
   task automatic apply_write(input csr_addr_t a, input xlen_t d);
      case (a)
         CSR_MSTATUS: if (!mret) begin                 // mret owns mstatus this cycle
            m_mie  = d[MSTATUS_MIE_BIT];
            m_mpie = d[MSTATUS_MPIE_BIT];
         end
         CSR_MIE:       m_mie_bits = d & 32'h0000_0888;   // Bits 11, 7 and 3 only
         CSR_MTVEC:     m_mtvec    = d & ~32'h3;
         CSR_MSCRATCH:  m_mscratch = d;
         CSR_MEPC:      m_mepc     = d & ~32'h3;
         CSR_MCAUSE:    m_mcause   = d;
         CSR_MCYCLE:    m_mcycle   = {old_cycle[63:32], d};   // Increment is lost
         CSR_MCYCLEH:   m_mcycle   = {d, old_cycle[31:0]};
         CSR_MINSTRET:  m_minstret = {old_instret[63:32], d};
         CSR_MINSTRETH: m_minstret = {d, old_instret[31:0]};
         default:       ;
      endcase
   endtask

   always @(posedge clk_in) begin
      if (reset) begin
         m_mie      = 1'b0;
         m_mpie     = 1'b0;
         m_mie_bits = '0;
         m_mtvec    = MTVEC_INIT;
         m_mscratch = '0;
         m_mepc     = '0;
         m_mcause   = '0;
         m_mcycle   = '0;
         m_minstret = '0;
      end else begin
         old_cycle   = m_mcycle;
         old_instret = m_minstret;
         m_mcycle    = m_mcycle + 1;
         if (retired)
            m_minstret = m_minstret + 1;
         if (exception_flag) begin                     // Trap entry beats wr and mret
            m_mepc   = {exception_pc, 2'b00};
            m_mcause = exception_cause;
            m_mpie   = m_mie;
            m_mie    = 1'b0;
         end else begin
            if (mret) begin
               m_mie  = m_mpie;
               m_mpie = 1'b1;
            end
            if (wr)
               apply_write(wr_addr, wr_data);
         end
      end
   end

   function automatic xlen_t live_mip();
      return (xlen_t'(ext_irq) << IRQ_MEI_BIT) | (xlen_t'(timer_irq) << IRQ_MTI_BIT) |
             (xlen_t'(sw_irq) << IRQ_MSI_BIT);
   endfunction

   // Expected read data and exists flag for one address
   function automatic xlen_t ref_value(input csr_addr_t a, output logic avail);
      avail = 1'b1;
      case (a)
         CSR_MSTATUS:   return 32'h0000_1800 | (xlen_t'(m_mpie) << 7) | (xlen_t'(m_mie) << 3);
         CSR_MIE:       return m_mie_bits;
         CSR_MTVEC:     return m_mtvec;
         CSR_MSCRATCH:  return m_mscratch;
         CSR_MEPC:      return m_mepc;
         CSR_MCAUSE:    return m_mcause;
         CSR_MIP:       return live_mip();
         CSR_MCYCLE:    return m_mcycle[31:0];
         CSR_MCYCLEH:   return m_mcycle[63:32];
         CSR_MINSTRET:  return m_minstret[31:0];
         CSR_MINSTRETH: return m_minstret[63:32];
         CSR_TIME:      return mtime[31:0];
         CSR_TIMEH:     return mtime[63:32];
         CSR_MHARTID:   return '0;
         default: begin
            avail = 1'b0;
            return '0;
         end
      endcase
   endfunction

   // --------------------
   // Compare tasks
   // --------------------
   task automatic check_xlen(input string name, input xlen_t got, input xlen_t exp);
      if (got !== exp) begin
         errors++;
         $display("Error %s: got %h, expected %h at %0t ns", name, got, exp, $time);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         errors++;
         $display("Error %s: got %h, expected %h at %0t ns", name, got, exp, $time);
      end
   endtask

   task automatic check_pc_word(input string name, input pc_word_t got, input pc_word_t exp);
      if (got !== exp) begin
         errors++;
         $display("Error %s: got %h, expected %h at %0t ns", name, got, exp, $time);
      end
   endtask

   // Outputs are settled at the falling edge, halfway between input changes
   always @(negedge clk_in) begin : compare
      xlen_t exp_data, pend, exp_cause;
      logic  exp_avail;
      if (!reset) begin
         exp_data = ref_value(rd_addr, exp_avail);
         check_xlen("rd_data", rd_data, exp_data);
         check_bit("rd_avail", rd_avail, exp_avail);
         pend = m_mie_bits & live_mip();
         check_bit("irq_flag", irq_flag, m_mie & (|pend));
         if (m_mie && pend != '0) begin              // Cause only matters with a request
            if (pend[IRQ_MEI_BIT])
               exp_cause = 32'h8000_000B;
            else if (pend[IRQ_MSI_BIT])
               exp_cause = 32'h8000_0003;
            else
               exp_cause = 32'h8000_0007;
            check_xlen("irq_cause", irq_cause, exp_cause);
         end
         check_pc_word("trap_pc", trap_pc, m_mtvec[31:2]);
         if (fwd_pending)                             // Model now holds the post-edge value
            check_xlen("nxt_rd_data", fwd_val, ref_value(fwd_addr, exp_avail));
         fwd_pending = fwd_en;
         fwd_addr    = nxt_wr_addr;
         fwd_val     = nxt_rd_data;
      end
   end

   // --------------------
   // Stimulus
   // --------------------
   task automatic step();                            // Advance one cycle, drop the strobes
      @(posedge clk_in);
      #5;
      wr             = 1'b0;
      nxt_wr         = 1'b0;
      exception_flag = 1'b0;
      mret           = 1'b0;
      retired        = 1'b0;
   endtask

   task automatic write_csr(input csr_addr_t a, input xlen_t d);
      wr      = 1'b1;
      wr_addr = a;
      wr_data = d;
      rd_addr = a;
      step();
   endtask

   task automatic end_test(input string name);
      tests++;
      $display("Test %0d %s: %0d errors", tests, name, errors - test_errors);
      test_errors = errors;
   endtask

   initial begin
      csr_addr_t a;
      xlen_t     d;
      void'($urandom(56145));
      {reset, wr, retired, exception_flag, mret, nxt_wr} = 6'b100000;
      {ext_irq, timer_irq, sw_irq, fwd_en, fwd_pending} = '0;
      {wr_addr, rd_addr, nxt_wr_addr} = '0;
      {wr_data, nxt_wr_data, exception_cause} = '0;
      exception_pc = '0;
      mtime        = 64'h0000_0012_3456_789A;
      repeat (16) @(posedge clk_in);
      #5;
      reset = 1'b0;
      foreach (addr_list[i]) begin                   // Reset values, mcycle keeps counting
         rd_addr = addr_list[i];
         step();
      end
      end_test("reset values");
      repeat (48) begin
         a = addr_list[$urandom_range(15)];
         write_csr(a, $urandom);
         rd_addr = a;
         step();
      end
      end_test("write masks");
      fwd_en = 1'b1;
      repeat (40) begin                              // Same write on both ports
         a = addr_list[$urandom_range(15)];
         d = $urandom;
         {wr, nxt_wr, wr_addr, nxt_wr_addr, wr_data, nxt_wr_data} = {2'b11, a, a, d, d};
         rd_addr = addr_list[$urandom_range(15)];
         step();
      end
      fwd_en = 1'b0;
      end_test("forward path");
      write_csr(CSR_MSTATUS, 32'h0000_0008);
      exception_flag  = 1'b1;
      exception_cause = $urandom;
      exception_pc    = pc_word_t'($urandom);
      write_csr(CSR_MEPC, $urandom);                 // Loses to the exception
      foreach (addr_list[i]) begin
         mret    = (i == 8);
         rd_addr = addr_list[i % 6];
         step();
      end
      write_csr(CSR_MSTATUS, 32'h0000_0000);         // Both enables clear before a second mret
      mret    = 1'b1;                                // mpie gets set even from zero
      rd_addr = CSR_MSTATUS;
      step();
      step();
      end_test("trap entry and mret");
      write_csr(CSR_MTVEC, $urandom);
      write_csr(CSR_MIE, 32'hFFFF_FFFF);
      write_csr(CSR_MSTATUS, 32'h0000_0008);
      repeat (32) begin
         {ext_irq, timer_irq, sw_irq} = 3'($urandom);
         rd_addr = CSR_MIP;
         step();
      end
      {ext_irq, timer_irq, sw_irq} = 3'b000;
      end_test("interrupt priority");
      for (int i = 0; i < 32; i++) begin
         retired = 1'($urandom);
         mtime   = {$urandom, $urandom};
         rd_addr = cnt_addr[i % 4];
         step();
      end
      end_test("counters and time");
      errors += UUT.checks.failures;
      $display("Tests run: %0d, errors: %0d", tests, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

   initial begin                                     // Each test stays well under 200 cycles
      #(NUM_TESTS * 200 * PERIOD);
      $display("Watchdog timeout: the tests did not complete in time");
      $display("Errors found");
      $finish;
   end

endmodule

`default_nettype wire

// File: build.f
common/csr_pkg.sv
csr_file/csr_next_value.sv
csr_file/csr_registers.sv
csr_file/csr_read_mux.sv
hdl/trap_control.sv
hdl/csr_unit.sv
tb/csr_unit_assertions.sv
tb/csr_unit_tb.sv
